// File: Bender.yml
package:
  name: debug_unit

sources:
  - common/debug_pkg.sv
  - uart/uart_rx.sv
  - uart/uart_tx.sv
  - hdl/program_loader.sv
  - hdl/state_dumper.sv
  - hdl/debug_unit.sv
  - target: test
    files:
      - sim/debug_unit_assertions.sv
      - sim/tb_debug_unit.sv

// File: common/debug_pkg.sv
`default_nettype none

package debug_pkg;

    // One 32-bit serial word
    typedef logic [31:0] word_t;

    ////////////////////////////////////////
    // Serial frame timing
    ////////////////////////////////////////

    localparam int unsigned clks_per_bit = 8;

    ////////////////////////////////////////
    // Dump layout
    ////////////////////////////////////////

    localparam int unsigned num_regs          = 32;
    localparam int unsigned num_mem_words     = 20;
    localparam int unsigned num_stages        = 5;
    // Fetch, decode, execute, memory, writeback
    localparam int unsigned latch_counts [num_stages] = '{2, 6, 6, 4, 2};
    localparam int unsigned num_latch_signals = 20;
    // Pc word plus the three blocks
    localparam int unsigned dump_words = 1 + num_regs + num_mem_words + num_latch_signals;

    // Ends program loading, never written to memory
    localparam word_t halt_word = 32'h7FFF_FFFE;

    // Dumper phase encodings
    localparam logic [2:0] ph_idle   = 3'd0;
    localparam logic [2:0] ph_pc     = 3'd1;
    localparam logic [2:0] ph_regs   = 3'd2;
    localparam logic [2:0] ph_mem    = 3'd3;
    localparam logic [2:0] ph_latch  = 3'd4;
    localparam logic [2:0] ph_wait   = 3'd5;
    localparam logic [2:0] ph_finish = 3'd6;

    // First received word is a command, later ones are program words
    typedef union packed {
        word_t raw;
        struct packed {
            logic [30:0] reserved;
            logic        step_mode;
        } fields;
    } debug_cmd_u;

endpackage

`default_nettype wire

// File: filelist.f
common/debug_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/program_loader.sv
hdl/state_dumper.sv
hdl/debug_unit.sv
sim/debug_unit_assertions.sv
sim/tb_debug_unit.sv

// File: hdl/debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit
    import debug_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    input  word_t      pc,
    input  word_t      reg_data,
    input  word_t      mem_data,
    input  word_t      latch_data,
    output logic       tx,
    output word_t      debug_address,
    output logic [6:0] latch_select,
    output logic       stall,
    output logic       dump_active,
    output logic       imem_we,
    output word_t      imem_addr,
    output word_t      imem_data,
    output logic       load_active
);

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       step_mode;
    word_t      last_addr;
    logic       tx_start;
    word_t      tx_word;
    logic       tx_done;

    uart_rx u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    program_loader u_program_loader (
        .clk         (clk),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .load_active (load_active),
        .step_mode   (step_mode),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .last_addr   (last_addr)
    );

    state_dumper u_state_dumper (
        .clk           (clk),
        .rst           (rst),
        .load_active   (load_active),
        .step_mode     (step_mode),
        .last_addr     (last_addr),
        .rx_valid      (rx_valid),
        .pc            (pc),
        .reg_data      (reg_data),
        .mem_data      (mem_data),
        .latch_data    (latch_data),
        .tx_done       (tx_done),
        .tx_start      (tx_start),
        .tx_word       (tx_word),
        .debug_address (debug_address),
        .latch_select  (latch_select),
        .stall         (stall),
        .dump_active   (dump_active)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_word  (tx_word),
        .tx       (tx),
        .tx_done  (tx_done)
    );

endmodule

`default_nettype wire

// File: hdl/program_loader.sv
`timescale 1ns/1ps
`default_nettype none

module program_loader
    import debug_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    output logic       load_active,
    output logic       step_mode,
    output logic       imem_we,
    output word_t      imem_addr,
    output word_t      imem_data,
    output word_t      last_addr
);

    logic [1:0]  byte_cnt;
    logic [23:0] byte_sr;
    logic        in_program;
    logic        word_done;
    word_t       wr_ptr;
    debug_cmd_u  rx_word;

    // Fourth byte completes the word
    assign rx_word.raw = {rx_byte, byte_sr};
    assign word_done   = rx_valid && load_active && byte_cnt == 2'd3;

    always_ff @(posedge clk)
    begin
        if (rx_valid)
            byte_sr <= {rx_byte, byte_sr[23:8]};
        if (word_done)
            imem_data <= rx_word.raw;
    end

    ////////////////////////////////////////
    // Command word, then program words
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            byte_cnt    <= '0;
            in_program  <= 1'b0;
            load_active <= 1'b1;
            step_mode   <= 1'b0;
            imem_we     <= 1'b0;
            imem_addr   <= '0;
            wr_ptr      <= '0;
            last_addr   <= '1;
        end
        else
        begin
            imem_we <= 1'b0;
            if (rx_valid && load_active)
                byte_cnt <= byte_cnt + 2'd1;
            if (word_done)
            begin
                if (!in_program)
                begin
                    step_mode  <= rx_word.fields.step_mode;
                    in_program <= 1'b1;
                end
                else if (rx_word.raw == halt_word)
                    load_active <= 1'b0;
                else
                begin
                    imem_we   <= 1'b1;
                    imem_addr <= wr_ptr;
                    last_addr <= wr_ptr;
                    wr_ptr    <= wr_ptr + 32'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/state_dumper.sv
`timescale 1ns/1ps
`default_nettype none

module state_dumper
    import debug_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load_active,
    input  logic       step_mode,
    input  word_t      last_addr,
    input  logic       rx_valid,
    input  word_t      pc,
    input  word_t      reg_data,
    input  word_t      mem_data,
    input  word_t      latch_data,
    input  logic       tx_done,
    output logic       tx_start,
    output word_t      tx_word,
    output word_t      debug_address,
    output logic [6:0] latch_select,
    output logic       stall,
    output logic       dump_active
);

    logic [2:0] phase;
    logic [2:0] next_phase;
    logic [2:0] stage;
    logic [3:0] sig;
    logic       batch_hold;
    logic       step_release;
    logic       trigger;

    assign trigger = step_mode ? rx_valid : (pc == last_addr + 32'd1);

    assign latch_select = {stage, sig};

    // Step mode lets the core run for a single cycle after each dump
    assign stall = step_mode ? (!load_active && !step_release) : batch_hold;

    always_ff @(posedge clk)
    begin
        case (phase)
            ph_pc:    tx_word <= pc;
            ph_regs:  tx_word <= reg_data;
            ph_mem:   tx_word <= mem_data;
            ph_latch: tx_word <= latch_data;
            default:  tx_word <= tx_word;
        endcase
    end

    ////////////////////////////////////////
    // Dump sequence
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            phase         <= ph_idle;
            next_phase    <= ph_idle;
            stage         <= '0;
            sig           <= '0;
            debug_address <= '0;
            tx_start      <= 1'b0;
            batch_hold    <= 1'b0;
            step_release  <= 1'b0;
            dump_active   <= 1'b0;
        end
        else
        begin
            tx_start     <= 1'b0;
            step_release <= 1'b0;
            case (phase)
                ph_idle:
                begin
                    if (!load_active && trigger)
                    begin
                        phase       <= ph_pc;
                        dump_active <= 1'b1;
                        if (!step_mode)
                            batch_hold <= 1'b1;
                    end
                end
                ph_pc:
                begin
                    tx_start      <= 1'b1;
                    debug_address <= '0;
                    next_phase    <= ph_regs;
                    phase         <= ph_wait;
                end
                ph_regs:
                begin
                    tx_start <= 1'b1;
                    phase    <= ph_wait;
                    if (debug_address == word_t'(num_regs - 1))
                    begin
                        debug_address <= '0;
                        next_phase    <= ph_mem;
                    end
                    else
                        debug_address <= debug_address + 32'd1;
                end
                ph_mem:
                begin
                    tx_start <= 1'b1;
                    phase    <= ph_wait;
                    if (debug_address == word_t'(num_mem_words - 1))
                    begin
                        debug_address <= '0;
                        stage         <= '0;
                        sig           <= '0;
                        next_phase    <= ph_latch;
                    end
                    else
                        debug_address <= debug_address + 32'd1;
                end
                ph_latch:
                begin
                    tx_start <= 1'b1;
                    phase    <= ph_wait;
                    // Last signal of this stage
                    if (sig == 4'(latch_counts[stage] - 1))
                    begin
                        sig <= '0;
                        if (stage == 3'(num_stages - 1))
                        begin
                            stage      <= '0;
                            next_phase <= ph_finish;
                        end
                        else
                            stage <= stage + 3'd1;
                    end
                    else
                        sig <= sig + 4'd1;
                end
                ph_wait:
                begin
                    if (tx_done)
                        phase <= next_phase;
                end
                ph_finish:
                begin
                    dump_active <= 1'b0;
                    // Batch mode ends here for the rest of the run
                    if (step_mode)
                    begin
                        step_release <= 1'b1;
                        phase        <= ph_idle;
                    end
                end
                default:
                    phase <= ph_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sim/debug_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit_assertions (
    input logic clk,
    input logic rst,
    input logic imem_we,
    input logic load_active,
    input logic tx_start,
    input logic tx_done,
    input logic dump_active
);

    // A word is in flight on the transmitter
    logic sending;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sending <= 1'b0;
        else if (tx_start)
            sending <= 1'b1;
        else if (tx_done)
            sending <= 1'b0;
    end

    write_while_loading: assert property (@(posedge clk) disable iff (rst)
        imem_we |-> load_active)
        else $error("imem_we seen after loading ended");

    start_inside_dump: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> dump_active)
        else $error("tx_start seen outside a dump");

    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !sending)
        else $error("tx_start seen while a word is still being sent");

endmodule

`default_nettype wire

// File: sim/tb_debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debug_unit
    import debug_pkg::*;
();

    localparam int unsigned clk_period     = 40;
    localparam int unsigned num_step_dumps = 3;
    localparam int unsigned max_prog_words = 12;
    // Cycles for one 40-bit word on the serial line
    localparam int unsigned word_cycles    = 40 * clks_per_bit;
    // Two loads, one batch dump, the step dumps with trigger bytes, then a margin
    localparam int unsigned budget_words   =
        2 * (max_prog_words + 2) + (1 + num_step_dumps) * (dump_words + 1) + 20;

    logic       clk;
    logic       rst;
    logic       rx;
    word_t      pc = '0;
    word_t      reg_data;
    word_t      mem_data;
    word_t      latch_data;
    logic       tx;
    word_t      debug_address;
    logic [6:0] latch_select;
    logic       stall;
    logic       dump_active;
    logic       imem_we;
    word_t      imem_addr;
    word_t      imem_data;
    logic       load_active;

    word_t reg_table [32];
    word_t mem_table [32];
    word_t latch_table [8][16];

    word_t prog [$];
    word_t wr_addrs [$];
    word_t wr_data [$];
    word_t tx_words [$];

    int unsigned errors         = 0;
    int unsigned window_errors  = 0;
    int unsigned checks         = 0;
    int unsigned tests          = 0;
    int unsigned framing_errors = 0;
    int unsigned tx_bytes       = 0;

    debug_unit u_dut (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .pc            (pc),
        .reg_data      (reg_data),
        .mem_data      (mem_data),
        .latch_data    (latch_data),
        .tx            (tx),
        .debug_address (debug_address),
        .latch_select  (latch_select),
        .stall         (stall),
        .dump_active   (dump_active),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .load_active   (load_active)
    );

    bind debug_unit debug_unit_assertions u_assertions (
        .clk         (clk),
        .rst         (rst),
        .imem_we     (imem_we),
        .load_active (load_active),
        .tx_start    (tx_start),
        .tx_done     (tx_done),
        .dump_active (dump_active)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Core model
    ////////////////////////////////////////

    assign reg_data   = reg_table[debug_address[4:0]];
    assign mem_data   = mem_table[debug_address[4:0]];
    assign latch_data = latch_table[latch_select[6:4]][latch_select[3:0]];

    // Pc runs from 0 once loading ends and holds under stall
    always @(negedge clk)
    begin
        if (rst || load_active)
            pc <= '0;
        else if (!stall)
            pc <= pc + 32'd1;
    end

    always @(negedge clk)
    begin
        if (imem_we)
        begin
            wr_addrs.push_back(imem_addr);
            wr_data.push_back(imem_data);
        end
    end

    ////////////////////////////////////////
    // Serial decoder for tx
    ////////////////////////////////////////

    initial
    begin : tx_decoder
        logic [7:0] byte_val;
        word_t      word_val;
        int         byte_idx;
        byte_idx = 0;
        word_val = '0;
        forever
        begin
            @(negedge clk);
            if (rst)
                byte_idx = 0;
            else if (tx === 1'b0)
            begin
                // Middle of the start bit
                repeat (clks_per_bit / 2) @(negedge clk);
                if (tx !== 1'b0)
                    framing_error("start bit on tx did not stay low");
                for (int b = 0; b < 8; b++)
                begin
                    repeat (clks_per_bit) @(negedge clk);
                    byte_val[b] = tx;
                end
                repeat (clks_per_bit) @(negedge clk);
                if (tx !== 1'b1)
                    framing_error("stop bit on tx was not high");
                tx_bytes++;
                word_val[byte_idx*8 +: 8] = byte_val;
                if (byte_idx == 3)
                begin
                    tx_words.push_back(word_val);
                    byte_idx = 0;
                end
                else
                    byte_idx++;
            end
        end
    end

    initial
    begin
        #(budget_words * word_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d word times", budget_words);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_select(input string name, input logic [6:0] got,
                                input logic [6:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    // Bad start or stop bit on tx
    task automatic framing_error(input string msg);
        framing_errors++;
        $display("Framing error at %0t: %s", $time, msg);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == window_errors)
            $display("test %0d %s: pass", tests, name);
        else
            $display("test %0d %s: fail with %0d errors", tests, name, errors - window_errors);
        window_errors = errors;
    endtask

    ////////////////////////////////////////
    // Host side
    ////////////////////////////////////////

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic fill_tables();
        foreach (reg_table[i])
            reg_table[i] = $urandom;
        foreach (mem_table[i])
            mem_table[i] = $urandom;
        foreach (latch_table[s, i])
            latch_table[s][i] = $urandom;
    endtask

    // Start bit, eight data bits lsb first, stop bit
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            rx = frame[i];
            repeat (clks_per_bit - 1) @(negedge clk);
        end
    endtask

    task automatic send_word(input word_t value);
        for (int i = 0; i < 4; i++)
            send_byte(value[i*8 +: 8]);
    endtask

    task automatic wait_dump(input logic level, input int unsigned max_cycles,
                             input string what);
        int unsigned n;
        n = 0;
        while (dump_active !== level && n < max_cycles)
        begin
            @(negedge clk);
            n++;
        end
        if (dump_active !== level)
            report_failure({"timed out waiting for ", what});
    endtask

    task automatic load_program(input logic step, input int unsigned len);
        word_t       cmd;
        word_t       w;
        int unsigned n;
        prog.delete();
        wr_addrs.delete();
        wr_data.delete();
        tx_words.delete();
        cmd    = $urandom;
        cmd[0] = step;
        send_word(cmd);
        for (int i = 0; i < len; i++)
        begin
            w = $urandom;
            while (w == halt_word)
                w = $urandom;
            prog.push_back(w);
            send_word(w);
        end
        // Loading must still be open when the halt word starts
        check_bit("load_active", load_active, 1'b1);
        send_word(halt_word);
        n = 0;
        while (load_active !== 1'b0 && n < 4 * clks_per_bit)
        begin
            @(negedge clk);
            n++;
        end
        if (load_active !== 1'b0)
            report_failure("load_active did not fall after the halt word");
    endtask

    ////////////////////////////////////////
    // Expected results
    ////////////////////////////////////////

    task automatic check_reset_values();
        check_bit("tx", tx, 1'b1);
        check_bit("stall", stall, 1'b0);
        check_bit("imem_we", imem_we, 1'b0);
        check_bit("dump_active", dump_active, 1'b0);
        check_bit("load_active", load_active, 1'b1);
        check_select("latch_select", latch_select, 7'd0);
    endtask

    task automatic check_writes();
        check_word("imem write count", word_t'(wr_addrs.size()), word_t'(prog.size()));
        for (int i = 0; i < prog.size() && i < wr_addrs.size(); i++)
        begin
            check_word("imem_addr", wr_addrs[i], word_t'(i));
            check_word("imem_data", wr_data[i], prog[i]);
        end
        check_bit("load_active", load_active, 1'b0);
    endtask

    // Pc, registers, memory, then latches by stage and signal
    task automatic check_dump(input word_t exp_pc);
        word_t expected [$];
        expected.push_back(exp_pc);
        for (int r = 0; r < num_regs; r++)
            expected.push_back(reg_table[r]);
        for (int m = 0; m < num_mem_words; m++)
            expected.push_back(mem_table[m]);
        for (int s = 0; s < num_stages; s++)
        begin
            for (int i = 0; i < latch_counts[s]; i++)
                expected.push_back(latch_table[s][i]);
        end
        check_word("dump word count", word_t'(tx_words.size()), word_t'(dump_words));
        for (int k = 0; k < expected.size() && k < tx_words.size(); k++)
            check_word($sformatf("dump word %0d", k), tx_words[k], expected[k]);
    endtask

    task automatic run_dump(input word_t exp_pc);
        wait_dump(1'b1, 64, "the dump to start");
        wait_dump(1'b0, (dump_words + 2) * word_cycles, "the dump to end");
        check_dump(exp_pc);
        check_select("latch_select", latch_select, 7'd0);
        check_word("debug_address", debug_address, '0);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        int unsigned len;
        void'($urandom(75010));
        rst = 1'b1;
        rx  = 1'b1;
        fill_tables();
        apply_reset();

        check_reset_values();
        finish_test("reset values");

        len = 5 + $urandom % (max_prog_words - 4);
        load_program(1'b0, len);
        check_writes();
        finish_test("batch program load");

        // Trigger is pc one past the last word
        run_dump(word_t'(len));
        repeat (2 * clks_per_bit) @(negedge clk);
        check_bit("stall", stall, 1'b1);
        check_word("pc", pc, word_t'(len));
        finish_test("batch dump");

        check_word("transmitted bytes", word_t'(tx_bytes), word_t'(4 * dump_words));
        check_word("framing errors", word_t'(framing_errors), '0);
        finish_test("byte framing");

        fill_tables();
        apply_reset();
        check_reset_values();
        len = 5 + $urandom % (max_prog_words - 4);
        load_program(1'b1, len);
        check_writes();
        repeat (clks_per_bit) @(negedge clk);
        check_bit("stall", stall, 1'b1);
        for (int d = 0; d < num_step_dumps; d++)
        begin
            tx_words.delete();
            send_byte(8'($urandom));
            run_dump(word_t'(d));
            // One free cycle for the core before it stalls again
            check_bit("stall", stall, 1'b0);
            @(negedge clk);
            check_bit("stall", stall, 1'b1);
            check_word("pc", pc, word_t'(d + 1));
        end
        check_word("framing errors", word_t'(framing_errors), '0);
        finish_test("step mode dumps");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import debug_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    logic       rx_meta;
    logic       rx_sync;
    logic       busy;
    logic [7:0] cycle_cnt;
    // 0 is the start bit, 1 to 8 data, 9 the stop bit
    logic [3:0] bit_idx;

    // Two-stage synchronizer, idles high
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy      <= 1'b0;
            cycle_cnt <= '0;
            bit_idx   <= '0;
            rx_valid  <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            if (!busy)
            begin
                if (!rx_sync)
                begin
                    busy      <= 1'b1;
                    cycle_cnt <= '0;
                    bit_idx   <= '0;
                end
            end
            else if (bit_idx == 4'd0)
            begin
                // Half a bit in, recheck the start bit
                if (cycle_cnt == 8'(clks_per_bit / 2 - 1))
                begin
                    cycle_cnt <= '0;
                    if (rx_sync)
                        busy <= 1'b0;
                    else
                        bit_idx <= 4'd1;
                end
                else
                    cycle_cnt <= cycle_cnt + 8'd1;
            end
            else if (cycle_cnt == 8'(clks_per_bit - 1))
            begin
                cycle_cnt <= '0;
                if (bit_idx == 4'd9)
                begin
                    busy     <= 1'b0;
                    rx_valid <= rx_sync;
                end
                else
                    bit_idx <= bit_idx + 4'd1;
            end
            else
                cycle_cnt <= cycle_cnt + 8'd1;
        end
    end

    // Data bits arrive lsb first
    always_ff @(posedge clk)
    begin
        if (busy && bit_idx != 4'd0 && bit_idx != 4'd9 && cycle_cnt == 8'(clks_per_bit - 1))
            rx_byte <= {rx_sync, rx_byte[7:1]};
    end

endmodule

`default_nettype wire

// File: uart/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import debug_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  tx_start,
    input  word_t tx_word,
    output logic  tx,
    output logic  tx_done
);

    logic [39:0] frame;
    logic [39:0] shift_reg;
    logic        busy;
    logic [7:0]  cycle_cnt;
    logic [5:0]  bit_cnt;

    ////////////////////////////////////////
    // Four 8N1 bytes, lsb byte first
    ////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            frame[i*10 +: 10] = {1'b1, tx_word[i*8 +: 8], 1'b0};
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shift_reg <= '1;
            busy      <= 1'b0;
            cycle_cnt <= '0;
            bit_cnt   <= '0;
            tx_done   <= 1'b0;
        end
        else
        begin
            tx_done <= 1'b0;
            if (!busy)
            begin
                if (tx_start)
                begin
                    shift_reg <= frame;
                    busy      <= 1'b1;
                    cycle_cnt <= '0;
                    bit_cnt   <= '0;
                end
            end
            else if (cycle_cnt == 8'(clks_per_bit - 1))
            begin
                cycle_cnt <= '0;
                // Shift in ones so the line idles high
                shift_reg <= {1'b1, shift_reg[39:1]};
                if (bit_cnt == 6'd39)
                begin
                    busy    <= 1'b0;
                    tx_done <= 1'b1;
                end
                else
                    bit_cnt <= bit_cnt + 6'd1;
            end
            else
                cycle_cnt <= cycle_cnt + 8'd1;
        end
    end

    assign tx = shift_reg[0];

endmodule

`default_nettype wire
